//--- flist.f
verilog/cpu_isa_pkg.sv
verilog/cpu_pipe_pkg.sv
verilog/cpu_fetch.sv
verilog/cpu_instr_queue.sv
verilog/cpu_regfile.sv
verilog/cpu_decode.sv
verilog/cpu_execute.sv
verilog/cpu_core.sv
verification/tb_cpu_core.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_cpu_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_cpu_core.sv
module tb_cpu_core;
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	localparam int PROG_LEN = 48;	// HALT sits at word PROG_LEN.
	localparam int MEM_WORDS = 64;
	localparam int RUN_TIMEOUT = 20000;
	localparam int DRAIN_CYCLES = 30;

	logic            clk = 1'b0;
	logic            i_reset;
	logic            i_hold;
	logic            o_i_access;
	logic [XLEN-1:0] o_i_addr;
	logic [XLEN-1:0] i_i_data;
	logic            i_i_ack;
	retire_t         o_retire;
	logic            o_halted;

	logic [15:0]     lfsr;
	logic [XLEN-1:0] mem [MEM_WORDS];
	logic [XLEN-1:0] model_regs [REG_COUNT];
	logic [XLEN-1:0] model_pc;
	logic [XLEN-1:0] req_addr;
	logic            halt_retired;
	logic            access_quiet;	// Bus went idle after the HALT.
	logic            first_req_seen;
	logic            after_reset_checked;
	int              bus_wait;
	int              hold_left;
	int              hold_acks;

	cpu_core uut (
		.clk(clk), .i_reset(i_reset), .i_hold(i_hold),
		.o_i_access(o_i_access), .o_i_addr(o_i_addr),
		.i_i_data(i_i_data), .i_i_ack(i_i_ack),
		.o_retire(o_retire), .o_halted(o_halted));

	initial begin
		forever #5 clk = ~clk;
	end

	// Galois LFSR stepped once per bit taken.
	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	// Words outside the program hold a HALT tagged with their own address.
	function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
		if (addr[XLEN-1:2] < MEM_WORDS)
			return mem[addr[7:2]];
		return {4'h8, addr[29:2] ^ 28'(addr[31:30])};
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		stop_with_error($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic build_program;
		instr_t   w;
		reg_idx_t recent [2];
		int       kind;
		int       off;
		recent[0] = reg_idx_t'(1);
		recent[1] = reg_idx_t'(2);
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = {4'h8, 12'h0, 16'(i)};
		for (int i = 0; i < PROG_LEN; i++) begin
			w = '0;
			kind = take_bits(3);
			w.rd = reg_idx_t'(take_bits(3));
			// Sources lean on the last two destinations.
			w.ra = take_bits(1) ? recent[take_bits(1)] : reg_idx_t'(take_bits(3));
			w.rb = take_bits(1) ? recent[take_bits(1)] : reg_idx_t'(take_bits(3));
			if (kind < 4) begin
				w.opcode = 4'(take_bits(3) % 5);	// ADD to XOR.
			end else if (kind < 6) begin
				w.opcode = 4'(OP_ADDI);
				w.imm = 16'(take_bits(16));
			end else begin
				w.opcode = take_bits(1) ? 4'(OP_BNE) : 4'(OP_BEQ);
				off = take_bits(2);
				if (off > PROG_LEN - 1 - i)
					off = PROG_LEN - 1 - i;	// Never past the HALT.
				w.imm = 16'(off);
			end
			if (kind < 6) begin
				recent[1] = recent[0];
				recent[0] = w.rd;
			end
			mem[i] = w;
		end
		mem[PROG_LEN] = {4'(OP_HALT), 28'h0};
	endtask

	// ISA reference step for one retire record.
	task automatic check_retire;
		instr_t          w;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] exp_val;
		logic [XLEN-1:0] next_pc;
		logic            exp_wr;
		w = fetch_word(model_pc);
		a = model_regs[w.ra];
		b = model_regs[w.rb];
		imm = {{(XLEN - 16){w.imm[15]}}, w.imm};
		next_pc = model_pc + 4;
		exp_wr = 1'b1;
		exp_val = '0;
		case (w.opcode)
		4'(OP_ADD):  exp_val = a + b;
		4'(OP_SUB):  exp_val = a - b;
		4'(OP_AND):  exp_val = a & b;
		4'(OP_OR):   exp_val = a | b;
		4'(OP_XOR):  exp_val = a ^ b;
		4'(OP_ADDI): exp_val = a + imm;
		default:     exp_wr = 1'b0;
		endcase
		if ((w.opcode == 4'(OP_BEQ) && a == b) || (w.opcode == 4'(OP_BNE) && a != b))
			next_pc = model_pc + 4 + imm * 4;	// Taken branch.
		assert (o_retire.pc == model_pc)
			else report_mismatch("o_retire.pc", o_retire.pc, model_pc);
		assert (o_retire.writes_rd == exp_wr)
			else report_mismatch("o_retire.writes_rd", XLEN'(o_retire.writes_rd), XLEN'(exp_wr));
		assert (o_retire.rd == w.rd)
			else report_mismatch("o_retire.rd", XLEN'(o_retire.rd), XLEN'(w.rd));
		assert (!exp_wr || o_retire.value == exp_val)
			else report_mismatch("o_retire.value", o_retire.value, exp_val);
		if (exp_wr && w.rd != '0)
			model_regs[w.rd] = exp_val;
		if (w.opcode >= 4'(OP_HALT))
			halt_retired = 1'b1;
		model_pc = next_pc;
	endtask

	// Samples outputs mid-cycle and drives the inputs for the next rising edge.
	always @(negedge clk) begin
		if (i_reset || !after_reset_checked) begin
			assert (!o_retire.valid) else stop_with_error("Retire valid during reset");
			assert (!o_halted) else stop_with_error("o_halted high during reset");
			assert (!i_reset || !o_i_access)
				else stop_with_error("Bus request during reset");
			after_reset_checked = !i_reset;
		end
		if (!i_reset) begin
			if (o_i_access && !first_req_seen) begin
				first_req_seen = 1'b1;
				assert (o_i_addr == '0) else report_mismatch("o_i_addr", o_i_addr, '0);
			end

			// One discarded response can land in the flush cycle.
			if (!i_hold)
				hold_acks = 0;
			else if (i_i_ack)
				hold_acks++;
			assert (hold_acks <= QUEUE_DEPTH + 1)
				else report_mismatch("acks during hold", XLEN'(hold_acks),
					XLEN'(QUEUE_DEPTH + 1));

			if (o_retire.valid) begin
				assert (!halt_retired) else stop_with_error("A retire followed the HALT");
				check_retire();
				hold_acks = 0;	// A retire may flush and refill the credits.
			end
			assert (o_halted == halt_retired)
				else report_mismatch("o_halted", XLEN'(o_halted), XLEN'(halt_retired));
			if (halt_retired) begin
				if (!o_i_access)
					access_quiet = 1'b1;
				assert (!(access_quiet && o_i_access))
					else stop_with_error("Bus request issued after the HALT");
			end

			if (i_i_ack) begin
				i_i_ack <= 1'b0;
				bus_wait = -1;	// The acked request is complete.
			end
			if (o_i_access) begin
				if (bus_wait < 0) begin
					bus_wait = take_bits(2);	// Latency of 1 to 4 cycles.
					req_addr = o_i_addr;
				end
				assert (o_i_addr == req_addr)
					else report_mismatch("o_i_addr", o_i_addr, req_addr);
				if (bus_wait == 0) begin
					i_i_ack <= 1'b1;
					i_i_data <= fetch_word(req_addr);
				end else begin
					bus_wait--;
				end
			end

			if (hold_left > 0)
				hold_left--;
			else if (take_bits(3) == 0)
				hold_left = take_bits(4);
			i_hold <= (hold_left != 0);
		end
	end

	initial begin
		i_reset = 1'b1;
		i_hold = 1'b0;
		i_i_ack = 1'b0;
		i_i_data = '0;
		lfsr = 16'd90;
		halt_retired = 1'b0;
		access_quiet = 1'b0;
		first_req_seen = 1'b0;
		after_reset_checked = 1'b0;
		bus_wait = -1;
		hold_left = 0;
		hold_acks = 0;
		model_pc = '0;
		for (int i = 0; i < REG_COUNT; i++)
			model_regs[i] = '0;
		build_program();

		repeat (3) @(negedge clk);
		i_reset <= 1'b0;

		for (int cyc = 0; cyc < RUN_TIMEOUT && !halt_retired; cyc++)
			@(negedge clk);
		if (!halt_retired) begin
			stop_with_error("Timeout waiting for the HALT to retire");
		end else begin
			repeat (DRAIN_CYCLES) @(negedge clk);
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

//--- verilog/cpu_core.sv
module cpu_core (
	input  logic                         clk,
	input  logic                         i_reset,
	input  logic                         i_hold,
	output logic                         o_i_access,
	output logic [cpu_isa_pkg::XLEN-1:0] o_i_addr,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_i_data,
	input  logic                         i_i_ack,
	output cpu_pipe_pkg::retire_t        o_retire,
	output logic                         o_halted
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	// Fetch and queue.
	logic            push;
	fetch_entry_t    push_entry;
	fetch_entry_t    head_entry;
	logic            queue_empty;
	logic            credit_return;

	// Decode and register file.
	logic            pop;
	reg_idx_t        ra_sel;
	reg_idx_t        rb_sel;
	logic [XLEN-1:0] ra_val;
	logic [XLEN-1:0] rb_val;
	decoded_t        dec_op;

	// Execute back to the front end.
	logic            redirect;
	logic [XLEN-1:0] redirect_pc;
	logic            flush;

	cpu_fetch fetch (
		.clk(clk), .i_reset(i_reset),
		.i_redirect(redirect), .i_redirect_pc(redirect_pc), .i_halt(o_halted),
		.i_credit_return(credit_return),
		.o_i_access(o_i_access), .o_i_addr(o_i_addr),
		.i_i_data(i_i_data), .i_i_ack(i_i_ack),
		.o_push(push), .o_entry(push_entry));

	cpu_instr_queue queue (
		.clk(clk), .i_reset(i_reset), .i_flush(flush),
		.i_push(push), .i_entry(push_entry), .i_pop(pop),
		.o_entry(head_entry), .o_empty(queue_empty),
		.o_credit_return(credit_return));

	cpu_decode decode (
		.clk(clk), .i_reset(i_reset), .i_flush(flush), .i_hold(i_hold),
		.i_entry(head_entry), .i_empty(queue_empty), .o_pop(pop),
		.o_ra_sel(ra_sel), .o_rb_sel(rb_sel), .i_ra(ra_val), .i_rb(rb_val),
		.o_op(dec_op));

	cpu_regfile regfile (
		.clk(clk), .i_reset(i_reset),
		.i_ra_sel(ra_sel), .i_rb_sel(rb_sel), .o_ra(ra_val), .o_rb(rb_val),
		.i_wb(o_retire));

	cpu_execute execute (
		.clk(clk), .i_reset(i_reset), .i_op(dec_op),
		.o_retire(o_retire),
		.o_redirect(redirect), .o_redirect_pc(redirect_pc),
		.o_flush(flush), .o_halted(o_halted));

endmodule

//--- verilog/cpu_execute.sv
module cpu_execute (
	input  logic                         clk,
	input  logic                         i_reset,
	input  cpu_pipe_pkg::decoded_t       i_op,
	output cpu_pipe_pkg::retire_t        o_retire,
	output logic                         o_redirect,
	output logic [cpu_isa_pkg::XLEN-1:0] o_redirect_pc,
	output logic                         o_flush,
	output logic                         o_halted
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	retire_t         ret_q;
	logic            in_valid;
	logic            fwd_ok;
	logic [XLEN-1:0] a;
	logic [XLEN-1:0] b;
	logic [XLEN-1:0] result;
	logic [XLEN-1:0] target;
	logic            taken;
	logic            is_halt;

	// The op behind a flush came from the squashed path.
	assign in_valid = i_op.valid && !o_flush && !o_halted;

	// Forward the previous result, it reaches the register file this cycle.
	assign fwd_ok = ret_q.valid && ret_q.writes_rd && (ret_q.rd != '0);
	assign a = (fwd_ok && (ret_q.rd == i_op.ra_idx)) ? ret_q.value : i_op.ra_val;
	assign b = (fwd_ok && (ret_q.rd == i_op.rb_idx)) ? ret_q.value : i_op.rb_val;

	assign target = i_op.pc + XLEN'(4) + {i_op.imm32[XLEN-3:0], 2'b00};
	assign is_halt = (i_op.op == OP_HALT);

	always_comb begin
		result = '0;
		taken = 1'b0;
		case (i_op.op)
		OP_ADD:  result = a + b;
		OP_SUB:  result = a - b;
		OP_AND:  result = a & b;
		OP_OR:   result = a | b;
		OP_XOR:  result = a ^ b;
		OP_ADDI: result = a + i_op.imm32;
		OP_BEQ:  taken = (a == b);
		OP_BNE:  taken = (a != b);
		default: result = '0;	// HALT produces no value.
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			ret_q.valid <= 1'b0;
			o_redirect <= 1'b0;
			o_flush <= 1'b0;
			o_halted <= 1'b0;
		end else begin
			ret_q.valid <= in_valid;
			o_redirect <= in_valid && taken;
			o_flush <= in_valid && (taken || is_halt);
			o_halted <= o_halted || (in_valid && is_halt);	// Sticky until reset.
		end

		ret_q.pc <= i_op.pc;
		ret_q.writes_rd <= i_op.writes_rd;
		ret_q.rd <= i_op.rd;
		ret_q.value <= result;
		o_redirect_pc <= target;
	end

	assign o_retire = ret_q;

endmodule

//--- verilog/cpu_decode.sv
module cpu_decode (
	input  logic                         clk,
	input  logic                         i_reset,
	input  logic                         i_flush,
	input  logic                         i_hold,
	input  cpu_pipe_pkg::fetch_entry_t   i_entry,
	input  logic                         i_empty,
	output logic                         o_pop,
	output cpu_isa_pkg::reg_idx_t        o_ra_sel,
	output cpu_isa_pkg::reg_idx_t        o_rb_sel,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_ra,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_rb,
	output cpu_pipe_pkg::decoded_t       o_op
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	instr_t          instr;
	opcode_e         op;
	logic            writes_rd;
	logic [XLEN-1:0] imm32;
	decoded_t        op_q;

	assign instr = i_entry.instr;
	assign o_pop = !i_empty && !i_hold;
	assign o_ra_sel = instr.ra;	// Register file is read in the pop cycle.
	assign o_rb_sel = instr.rb;
	assign imm32 = {{(XLEN - IMM_W){instr.imm[IMM_W-1]}}, instr.imm};
	assign o_op = op_q;

	always_comb begin
		if (instr.opcode <= OP_HALT)
			op = opcode_e'(instr.opcode);
		else
			op = OP_HALT;

		case (op)
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI: writes_rd = 1'b1;
		default: writes_rd = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_reset)
			op_q.valid <= 1'b0;
		else
			op_q.valid <= o_pop && !i_flush;	// Flush squashes the popped op.

		op_q.pc <= i_entry.pc;
		op_q.op <= op;
		op_q.rd <= instr.rd;
		op_q.ra_idx <= instr.ra;
		op_q.rb_idx <= instr.rb;
		op_q.ra_val <= i_ra;
		op_q.rb_val <= i_rb;
		op_q.imm32 <= imm32;
		op_q.writes_rd <= writes_rd;
	end

endmodule

//--- verilog/cpu_regfile.sv
module cpu_regfile (
	input  logic                         clk,
	input  logic                         i_reset,
	input  cpu_isa_pkg::reg_idx_t        i_ra_sel,
	input  cpu_isa_pkg::reg_idx_t        i_rb_sel,
	output logic [cpu_isa_pkg::XLEN-1:0] o_ra,
	output logic [cpu_isa_pkg::XLEN-1:0] o_rb,
	input  cpu_pipe_pkg::retire_t        i_wb
);
	import cpu_isa_pkg::*;

	logic [XLEN-1:0] regs [REG_COUNT];
	logic            wr_en;

	// r0 is never written, so it keeps reading as zero.
	assign wr_en = i_wb.valid && i_wb.writes_rd && (i_wb.rd != '0);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[i_wb.rd] <= i_wb.value;
		end
	end

	// Same-cycle write is passed straight to the readers.
	assign o_ra = (wr_en && (i_wb.rd == i_ra_sel)) ? i_wb.value : regs[i_ra_sel];
	assign o_rb = (wr_en && (i_wb.rd == i_rb_sel)) ? i_wb.value : regs[i_rb_sel];

endmodule

//--- verilog/cpu_instr_queue.sv
module cpu_instr_queue (
	input  logic                       clk,
	input  logic                       i_reset,
	input  logic                       i_flush,
	input  logic                       i_push,
	input  cpu_pipe_pkg::fetch_entry_t i_entry,
	input  logic                       i_pop,
	output cpu_pipe_pkg::fetch_entry_t o_entry,
	output logic                       o_empty,
	output logic                       o_credit_return
);
	import cpu_pipe_pkg::*;

	fetch_entry_t slots [QUEUE_DEPTH];
	queue_ptr_t   wr_ptr;
	queue_ptr_t   rd_ptr;
	credit_t      count;

	assign o_empty = (count == '0);
	assign o_entry = slots[rd_ptr];	// Head is visible before the pop.

	always_ff @(posedge clk) begin
		if (i_push)
			slots[wr_ptr] <= i_entry;
	end

	/*
	 * No full check: fetch only pushes against a credit, and credits
	 * in hand plus entries held never exceed the depth.
	 */
	always_ff @(posedge clk) begin
		if (i_reset || i_flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			o_credit_return <= 1'b0;
		end else begin
			if (i_push)
				wr_ptr <= wr_ptr + queue_ptr_t'(1);
			if (i_pop)
				rd_ptr <= rd_ptr + queue_ptr_t'(1);
			count <= count + credit_t'(i_push) - credit_t'(i_pop);
			o_credit_return <= i_pop;	// One credit per popped entry.
		end
	end

endmodule

//--- verilog/cpu_fetch.sv
module cpu_fetch (
	input  logic                         clk,
	input  logic                         i_reset,
	input  logic                         i_redirect,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_redirect_pc,
	input  logic                         i_halt,
	input  logic                         i_credit_return,
	output logic                         o_i_access,
	output logic [cpu_isa_pkg::XLEN-1:0] o_i_addr,
	input  logic [cpu_isa_pkg::XLEN-1:0] i_i_data,
	input  logic                         i_i_ack,
	output logic                         o_push,
	output cpu_pipe_pkg::fetch_entry_t   o_entry
);
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_WAIT,
		FETCH_DISCARD,	// Outstanding request belongs to a squashed path.
		FETCH_STOPPED
	} fetch_state_e;

	fetch_state_e    state;
	fetch_state_e    state_d;
	logic [XLEN-1:0] pc_q;	// Next address to request.
	logic [XLEN-1:0] addr_q;	// Held on the bus until the ack.
	logic [XLEN-1:0] issue_addr;
	logic            issue;
	logic            load_pc;
	logic            flush;
	credit_t         credits;
	credit_t         credit_sum;

	assign flush = i_redirect | i_halt;
	assign credit_sum = credits + credit_t'(i_credit_return);

	assign o_i_access = (state == FETCH_WAIT) || (state == FETCH_DISCARD);
	assign o_i_addr = addr_q;
	assign o_push = (state == FETCH_WAIT) && i_i_ack && !flush;
	assign o_entry = '{pc: addr_q, instr: instr_t'(i_i_data)};

	always_comb begin
		state_d = state;
		issue = 1'b0;
		issue_addr = pc_q;
		load_pc = 1'b0;
		case (state)
		FETCH_IDLE: begin
			if (i_halt) begin
				state_d = FETCH_STOPPED;
			end else if (i_redirect) begin
				issue = 1'b1;
				issue_addr = i_redirect_pc;
			end else if (credit_sum != '0) begin
				issue = 1'b1;
			end
		end
		FETCH_WAIT: begin
			if (i_i_ack) begin
				if (i_halt)
					state_d = FETCH_STOPPED;
				else if (i_redirect) begin
					issue = 1'b1;
					issue_addr = i_redirect_pc;
				end else if (credit_sum > credit_t'(1))
					issue = 1'b1;	// A credit is left after this one.
				else
					state_d = FETCH_IDLE;
			end else if (flush) begin
				state_d = FETCH_DISCARD;
				load_pc = i_redirect;
			end
		end
		FETCH_DISCARD: begin
			load_pc = i_redirect;
			if (i_i_ack)
				state_d = i_halt ? FETCH_STOPPED : FETCH_IDLE;
		end
		default: state_d = FETCH_STOPPED;	// Left only by reset.
		endcase
		if (issue)
			state_d = FETCH_WAIT;
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= FETCH_IDLE;
			pc_q <= '0;
		end else begin
			state <= state_d;
			if (issue)
				pc_q <= issue_addr + XLEN'(4);
			else if (load_pc)
				pc_q <= i_redirect_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (issue)
			addr_q <= issue_addr;
	end

	// A flush empties the queue, so every credit comes back at once.
	always_ff @(posedge clk) begin
		if (i_reset || flush)
			credits <= credit_t'(QUEUE_DEPTH);
		else if (o_push)
			credits <= credit_sum - credit_t'(1);
		else
			credits <= credit_sum;
	end

endmodule

//--- verilog/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

	import cpu_isa_pkg::*;

	// Depth must be a power of two, the queue pointers wrap naturally.
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);

	typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;
	typedef logic [CREDIT_W-1:0] credit_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		instr_t          instr;
	} fetch_entry_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		opcode_e         op;
		reg_idx_t        rd;
		reg_idx_t        ra_idx;
		reg_idx_t        rb_idx;
		logic [XLEN-1:0] ra_val;
		logic [XLEN-1:0] rb_val;
		logic [XLEN-1:0] imm32;
		logic            writes_rd;
	} decoded_t;

	// Also the register file write port.
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		logic            writes_rd;
		reg_idx_t        rd;
		logic [XLEN-1:0] value;
	} retire_t;

endpackage

//--- verilog/cpu_isa_pkg.sv
package cpu_isa_pkg;

	localparam int XLEN = 32;
	localparam int REG_COUNT = 8;
	localparam int REG_IDX_W = $clog2(REG_COUNT);
	localparam int IMM_W = 16;

	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Codes above OP_HALT are undefined and execute as HALT.
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,	// rd = ra + rb.
		OP_SUB  = 4'h1,	// rd = ra - rb.
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_ADDI = 4'h5,	// rd = ra + imm.
		OP_BEQ  = 4'h6,	// Taken when ra == rb.
		OP_BNE  = 4'h7,	// Taken when ra != rb.
		OP_HALT = 4'h8
	} opcode_e;

	/*
	 * Instruction word, most significant field first:
	 *   [31:28] opcode  [27:25] rd  [24:22] ra  [21:19] rb
	 *   [18:16] spare   [15:0]  imm, sign-extended to XLEN.
	 * Branch target is pc + 4 + imm * 4.
	 */
	typedef struct packed {
		logic [3:0]       opcode;
		reg_idx_t         rd;
		reg_idx_t         ra;
		reg_idx_t         rb;
		logic [2:0]       spare;
		logic [IMM_W-1:0] imm;
	} instr_t;

endpackage
